// File: rtl/hazard_pkg.sv
// hazard control package
// instruction field codes, function classes, timing counts and the
// decode and tracker records shared by the hazard-control blocks
`default_nettype none

package hazard_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;    // r0 is hardwired zero
    typedef logic [1:0]  t_time_t;

    localparam t_time_t TUSE_INF = 2'd3;    // operand never read early

    // opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_J        = 6'h02;
    localparam logic [5:0] OP_JAL      = 6'h03;
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_ADDI     = 6'h08;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_LW       = 6'h23;
    localparam logic [5:0] OP_SW       = 6'h2b;

    // funct codes under SPECIAL
    localparam logic [5:0] F_SLL   = 6'h00;
    localparam logic [5:0] F_SRL   = 6'h02;
    localparam logic [5:0] F_SRA   = 6'h03;
    localparam logic [5:0] F_JR    = 6'h08;
    localparam logic [5:0] F_JALR  = 6'h09;
    localparam logic [5:0] F_MFHI  = 6'h10;
    localparam logic [5:0] F_MTHI  = 6'h11;
    localparam logic [5:0] F_MFLO  = 6'h12;
    localparam logic [5:0] F_MTLO  = 6'h13;
    localparam logic [5:0] F_MULT  = 6'h18;
    localparam logic [5:0] F_MULTU = 6'h19;
    localparam logic [5:0] F_DIV   = 6'h1a;
    localparam logic [5:0] F_DIVU  = 6'h1b;
    localparam logic [5:0] F_ADD   = 6'h20;
    localparam logic [5:0] F_ADDU  = 6'h21;
    localparam logic [5:0] F_SUB   = 6'h22;
    localparam logic [5:0] F_SUBU  = 6'h23;
    localparam logic [5:0] F_AND   = 6'h24;
    localparam logic [5:0] F_OR    = 6'h25;
    localparam logic [5:0] F_XOR   = 6'h26;
    localparam logic [5:0] F_SLT   = 6'h2a;

    // funct codes under SPECIAL2
    localparam logic [5:0] F_CLZ   = 6'h20;
    localparam logic [5:0] F_CLO   = 6'h21;

    typedef enum logic [2:0] {
        CALC_R, CALC_I, MEM_READ, MEM_WRITE, BRANCH, JUMP, MULTDIV, NOP
    } func_class_e;

    typedef struct packed {
        func_class_e fclass;
        logic        mdu;   // touches HI/LO
        reg_addr_t   rs;    // zero when not read
        reg_addr_t   rt;    // zero when not read
        reg_addr_t   dest;  // zero when nothing is written
    } decode_t;

    // one in-flight instruction, all zeros is a bubble
    typedef struct packed {
        reg_addr_t dest;
        t_time_t   tnew;
    } stage_rec_t;

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

endpackage

`default_nettype wire

// File: rtl/instr_class.sv
// instruction classifier
// splits an ID-stage instruction into function class, the source
// registers it really reads and the register it writes
`timescale 1ns/10ps
`default_nettype none

module instr_class import hazard_pkg::*; (
    input  instr_t  instr,
    output decode_t dec
);

    logic [5:0] op;
    logic [5:0] funct;

    assign op    = instr[31:26];
    assign funct = instr[5:0];

    always_comb begin
        dec = '{fclass: NOP, mdu: 1'b0, rs: '0, rt: '0, dest: '0};
        case (op)
            OP_SPECIAL: begin
                case (funct)
                    F_SLL, F_SRL, F_SRA: begin
                        if (instr != '0) begin  // all-zero word stays a NOP
                            dec.fclass = CALC_R;
                            dec.rt     = instr[20:16];
                            dec.dest   = instr[15:11];
                        end
                    end
                    F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_SLT: begin
                        dec.fclass = CALC_R;
                        dec.rs     = instr[25:21];
                        dec.rt     = instr[20:16];
                        dec.dest   = instr[15:11];
                    end
                    F_JR, F_JALR: begin
                        dec.fclass = JUMP;
                        dec.rs     = instr[25:21];
                        dec.dest   = (funct == F_JALR) ? instr[15:11] : 5'd0;
                    end
                    F_MULT, F_MULTU, F_DIV, F_DIVU: begin
                        dec.fclass = MULTDIV;
                        dec.mdu    = 1'b1;
                        dec.rs     = instr[25:21];
                        dec.rt     = instr[20:16];
                    end
                    F_MFHI, F_MFLO: begin
                        dec.fclass = MULTDIV;
                        dec.mdu    = 1'b1;
                        dec.dest   = instr[15:11];
                    end
                    F_MTHI, F_MTLO: begin
                        dec.fclass = MULTDIV;
                        dec.mdu    = 1'b1;
                        dec.rs     = instr[25:21];
                    end
                    default: ;
                endcase
            end
            OP_SPECIAL2: begin
                if (funct == F_CLO || funct == F_CLZ) begin
                    dec.fclass = CALC_R;
                    dec.rs     = instr[25:21];
                    dec.dest   = instr[15:11];
                end
            end
            OP_ADDI, OP_ORI, OP_LUI, OP_LW: begin
                dec.fclass = (op == OP_LW) ? MEM_READ : CALC_I;
                dec.rs     = (op == OP_LUI) ? 5'd0 : instr[25:21];  // lui has no source
                dec.dest   = instr[20:16];
            end
            OP_SW, OP_BEQ, OP_BNE: begin
                dec.fclass = (op == OP_SW) ? MEM_WRITE : BRANCH;
                dec.rs     = instr[25:21];
                dec.rt     = instr[20:16];
            end
            OP_J, OP_JAL: begin
                dec.fclass = JUMP;
                dec.dest   = (op == OP_JAL) ? 5'd31 : 5'd0;     // link register
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/instr_timing.sv
// operand deadline and result timing table
// gives the cycles until rs and rt are needed (Tuse) and the cycles
// until the result exists (Tnew), both counted from the ID stage
`timescale 1ns/10ps
`default_nettype none

module instr_timing import hazard_pkg::*; (
    input  instr_t  instr,
    input  decode_t dec,
    output t_time_t tuse_rs,
    output t_time_t tuse_rt,
    output t_time_t tnew_id
);

    logic [5:0] op;
    logic [5:0] funct;
    logic       shift_imm;
    logic       count_lead;     // clo / clz
    logic       reg_jump;       // jr / jalr
    logic       links;          // jal / jalr
    logic       mdu_op;         // mult, multu, div, divu
    logic       mdu_read;       // mfhi / mflo

    assign op    = instr[31:26];
    assign funct = instr[5:0];

    assign shift_imm  = (op == OP_SPECIAL) &&
                        (funct == F_SLL || funct == F_SRL || funct == F_SRA);
    assign count_lead = (op == OP_SPECIAL2);
    assign reg_jump   = (op == OP_SPECIAL) && (funct == F_JR || funct == F_JALR);
    assign links      = (op == OP_JAL) || ((op == OP_SPECIAL) && funct == F_JALR);
    assign mdu_op     = (funct == F_MULT || funct == F_MULTU ||
                         funct == F_DIV  || funct == F_DIVU);
    assign mdu_read   = (funct == F_MFHI || funct == F_MFLO);

    always_comb begin
        tuse_rs = TUSE_INF;
        tuse_rt = TUSE_INF;
        tnew_id = 2'd0;
        case (dec.fclass)
            CALC_R: begin
                tuse_rs = shift_imm ? TUSE_INF : 2'd1;
                tuse_rt = count_lead ? TUSE_INF : 2'd1;
                tnew_id = 2'd2;
            end
            CALC_I: begin
                tuse_rs = (op == OP_LUI) ? TUSE_INF : 2'd1;
                tnew_id = (op == OP_LUI) ? 2'd1 : 2'd2;  // lui result ready in EX
            end
            MEM_READ: begin
                tuse_rs = 2'd1;
                tnew_id = 2'd3;
            end
            MEM_WRITE: begin
                tuse_rs = 2'd1;
                tuse_rt = 2'd2;     // store data needed in MEM
            end
            BRANCH: begin
                tuse_rs = 2'd0;     // compared in ID
                tuse_rt = 2'd0;
            end
            JUMP: begin
                tuse_rs = reg_jump ? 2'd0 : TUSE_INF;
                tnew_id = links ? 2'd1 : 2'd0;
            end
            MULTDIV: begin
                tuse_rs = mdu_read ? TUSE_INF : 2'd1;
                tuse_rt = mdu_op ? 2'd1 : TUSE_INF;
                tnew_id = mdu_read ? 2'd2 : 2'd0;
            end
            default: ;      // NOP reads and writes nothing
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/stage_reg.sv
// pipeline tracker register
// holds one in-flight record, loads a bubble on reset or clear
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clr,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            q <= '0;    // bubble
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
// stall decision
// stalls ID when a source is produced too late by EX or MEM, or when
// a HI/LO instruction meets a busy multiply/divide unit
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import hazard_pkg::*; (
    input  decode_t    dec,
    input  t_time_t    tuse_rs,
    input  t_time_t    tuse_rt,
    input  stage_rec_t ex_rec,
    input  stage_rec_t mem_rec,
    input  logic       mdu_busy,
    output logic       stall_pc,
    output logic       stall_id,
    output logic       clr_ex
);

    logic stall_rs;
    logic stall_rt;
    logic stall_mdu;
    logic stall;

    // result arrives after the operand deadline
    assign stall_rs = (dec.rs != 5'd0) && (
        (ex_rec.dest == dec.rs && ex_rec.tnew > tuse_rs) ||
        (mem_rec.dest == dec.rs && mem_rec.tnew > tuse_rs));

    assign stall_rt = (dec.rt != 5'd0) && (
        (ex_rec.dest == dec.rt && ex_rec.tnew > tuse_rt) ||
        (mem_rec.dest == dec.rt && mem_rec.tnew > tuse_rt));

    assign stall_mdu = dec.mdu && mdu_busy;

    assign stall = stall_rs || stall_rt || stall_mdu;

    // freeze PC and ID, push a bubble into EX
    assign stall_pc = stall;
    assign stall_id = stall;
    assign clr_ex   = stall;

endmodule

`default_nettype wire

// File: rtl/forward_ctrl.sv
// ID operand forwarding select
// picks EX, MEM or register file for each source read in ID
`timescale 1ns/10ps
`default_nettype none

module forward_ctrl import hazard_pkg::*; (
    input  decode_t    dec,
    input  stage_rec_t ex_rec,
    input  stage_rec_t mem_rec,
    output fwd_sel_e   fwd_rs,
    output fwd_sel_e   fwd_rt
);

    // EX checked first since it carries the newer value
    function automatic fwd_sel_e pick(reg_addr_t src, stage_rec_t ex, stage_rec_t mem);
        fwd_sel_e sel;
        sel = FWD_RF;
        if (src != 5'd0) begin
            if (ex.dest == src && ex.tnew == 2'd0) begin
                sel = FWD_EX;
            end else if (mem.dest == src && mem.tnew == 2'd0) begin
                sel = FWD_MEM;
            end
        end
        return sel;
    endfunction

    assign fwd_rs = pick(dec.rs, ex_rec, mem_rec);
    assign fwd_rt = pick(dec.rt, ex_rec, mem_rec);

endmodule

`default_nettype wire

// File: rtl/hazard_top.sv
// hazard control top
// decodes the ID instruction, tracks EX and MEM results and drives
// the stall controls and the ID forwarding selects
`timescale 1ns/10ps
`default_nettype none

module hazard_top import hazard_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  instr_t   instr_id,
    input  logic     mdu_busy,
    output logic     stall_pc,
    output logic     stall_id,
    output logic     clr_ex,
    output fwd_sel_e fwd_rs,
    output fwd_sel_e fwd_rt
);

    decode_t    dec;
    t_time_t    tuse_rs;
    t_time_t    tuse_rt;
    t_time_t    tnew_id;
    stage_rec_t ex_d;       // record entering EX
    stage_rec_t ex_rec;
    stage_rec_t mem_d;      // record entering MEM
    stage_rec_t mem_rec;

    // one stage closer to the result, floor at zero
    function automatic t_time_t age(t_time_t t);
        return (t == 2'd0) ? 2'd0 : t - 2'd1;
    endfunction

    instr_class u_class (
        .instr (instr_id),
        .dec   (dec)
    );

    instr_timing u_timing (
        .instr   (instr_id),
        .dec     (dec),
        .tuse_rs (tuse_rs),
        .tuse_rt (tuse_rt),
        .tnew_id (tnew_id)
    );

    assign ex_d  = '{dest: dec.dest, tnew: age(tnew_id)};
    assign mem_d = '{dest: ex_rec.dest, tnew: age(ex_rec.tnew)};

    stage_reg #(.payload_t(stage_rec_t)) id_ex_trk (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (clr_ex),    // stalled instruction leaves a bubble
        .d     (ex_d),
        .q     (ex_rec)
    );

    stage_reg #(.payload_t(stage_rec_t)) ex_mem_trk (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (1'b0),      // EX never stalls
        .d     (mem_d),
        .q     (mem_rec)
    );

    hazard_unit u_hazard (
        .dec      (dec),
        .tuse_rs  (tuse_rs),
        .tuse_rt  (tuse_rt),
        .ex_rec   (ex_rec),
        .mem_rec  (mem_rec),
        .mdu_busy (mdu_busy),
        .stall_pc (stall_pc),
        .stall_id (stall_id),
        .clr_ex   (clr_ex)
    );

    forward_ctrl u_fwd (
        .dec     (dec),
        .ex_rec  (ex_rec),
        .mem_rec (mem_rec),
        .fwd_rs  (fwd_rs),
        .fwd_rt  (fwd_rt)
    );

endmodule

`default_nettype wire

// File: test/hazard_assert.sv
// hazard control checks
// concurrent properties on the stall and forward outputs, bound into the top
`timescale 1ns/10ps
`default_nettype none

module hazard_assert import hazard_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     stall_id,
    input logic     clr_ex,
    input logic     mdu_busy,
    input fwd_sel_e fwd_rs,
    input fwd_sel_e fwd_rt
);

    logic reg_stall;    // stall not caused by the mdu

    assign reg_stall = stall_id && !mdu_busy;

    // a held instruction waits at most two cycles for a register
    reg_stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        reg_stall && $past(reg_stall) |-> !$past(reg_stall, 2))
        else $error("register stall lasted more than two cycles");

    // empty trackers in reset
    reset_selects_rf: assert property (@(posedge clk)
        !rst_n |-> (fwd_rs == FWD_RF) && (fwd_rt == FWD_RF))
        else $error("forward select not register file during reset");

    // bubble in EX after a stall cycle
    bubble_not_ex: assert property (@(posedge clk) disable iff (!rst_n)
        clr_ex |=> (fwd_rs != FWD_EX))
        else $error("rs forwarded from EX right after a bubble was inserted");

endmodule

bind hazard_top hazard_assert u_check (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall_id (stall_id),
    .clr_ex   (clr_ex),
    .mdu_busy (mdu_busy),
    .fwd_rs   (fwd_rs),
    .fwd_rt   (fwd_rt)
);

`default_nettype wire

// File: test/hazard_tb.sv
// hazard control testbench
// applies a table of ID instructions, one per cycle, and checks the
// stall controls and forward selects against hand-worked expectations
`timescale 1ns/10ps
`default_nettype none

module hazard_tb import hazard_pkg::*; ();

    typedef struct packed {
        int       test_id;
        instr_t   instr;
        logic     busy;
        logic     stall;
        fwd_sel_e fwd_rs;
        fwd_sel_e fwd_rt;
    } row_t;

    logic     clk;
    logic     rst_n;
    instr_t   instr_id;
    logic     mdu_busy;
    logic     stall_pc;
    logic     stall_id;
    logic     clr_ex;
    fwd_sel_e fwd_rs;
    fwd_sel_e fwd_rt;

    row_t   table_q[$];
    integer seed = 32'he45d_0e05;
    int     row_errors;
    int     tests_passed;
    int     tests_failed;
    int     cycle_cnt = 0;
    int     cycle_limit;

    hazard_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr_id (instr_id),
        .mdu_busy (mdu_busy),
        .stall_pc (stall_pc),
        .stall_id (stall_id),
        .clr_ex   (clr_ex),
        .fwd_rs   (fwd_rs),
        .fwd_rt   (fwd_rt)
    );

    always #20 clk = ~clk;

    // guard against a stuck run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic instr_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                     logic [5:0] funct);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    // immediate is don't-care for hazards, so random
    function automatic instr_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt);
        logic [31:0] r;
        r = $random(seed);
        return {op, rs, rt, r[15:0]};
    endfunction

    task automatic add_row(input int test_id, input instr_t instr, input logic busy,
                           input logic stall, input fwd_sel_e rs_sel, input fwd_sel_e rt_sel);
        table_q.push_back(row_t'{test_id, instr, busy, stall, rs_sel, rt_sel});
    endtask

    task automatic check(input string name, input logic [7:0] actual,
                         input logic [7:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual %h expected %h", name, actual, expected);
            row_errors++;
        end
    endtask

    task automatic build_table();
        instr_t ins;
        // 6: trackers empty after reset, even though add r8 sat in ID
        add_row(6, enc_r(8, 8, 10, F_ADD), 1'b0, 1'b0, FWD_RF, FWD_RF);
        add_row(6, 32'h0, 1'b0, 1'b0, FWD_RF, FWD_RF);
        // 1: load-use, one stall
        add_row(1, enc_i(OP_LW, 1, 8), 1'b0, 1'b0, FWD_RF, FWD_RF);
        ins = enc_r(8, 9, 10, F_ADD);
        add_row(1, ins, 1'b0, 1'b1, FWD_RF, FWD_RF);
        add_row(1, ins, 1'b0, 1'b0, FWD_RF, FWD_RF);   // mem tnew still 1
        // 2: alu then branch, then load then branch
        add_row(2, enc_r(1, 2, 9, F_ADD), 1'b0, 1'b0, FWD_RF, FWD_RF);
        ins = enc_i(OP_BEQ, 9, 3);
        add_row(2, ins, 1'b0, 1'b1, FWD_RF, FWD_RF);
        add_row(2, ins, 1'b0, 1'b0, FWD_MEM, FWD_RF);
        add_row(2, enc_i(OP_LW, 0, 11), 1'b0, 1'b0, FWD_RF, FWD_RF);
        ins = enc_i(OP_BEQ, 3, 11);
        add_row(2, ins, 1'b0, 1'b1, FWD_RF, FWD_RF);
        add_row(2, ins, 1'b0, 1'b1, FWD_RF, FWD_RF);
        add_row(2, ins, 1'b0, 1'b0, FWD_RF, FWD_RF);
        // 3: r0 and unrelated registers
        add_row(3, enc_i(OP_LW, 2, 0), 1'b0, 1'b0, FWD_RF, FWD_RF);
        add_row(3, enc_r(0, 0, 5, F_ADD), 1'b0, 1'b0, FWD_RF, FWD_RF);
        add_row(3, enc_r(13, 14, 12, F_OR), 1'b0, 1'b0, FWD_RF, FWD_RF);
        add_row(3, enc_i(OP_ORI, 16, 15), 1'b0, 1'b0, FWD_RF, FWD_RF);
        add_row(3, enc_i(OP_SW, 18, 17), 1'b0, 1'b0, FWD_RF, FWD_RF);
        // 4: lui result forwarded from EX, then from MEM, then a stalled jalr
        add_row(4, enc_i(OP_LUI, 0, 4), 1'b0, 1'b0, FWD_RF, FWD_RF);
        add_row(4, enc_r(4, 0, 0, F_JR), 1'b0, 1'b0, FWD_EX, FWD_RF);
        add_row(4, enc_r(4, 4, 20, F_ADD), 1'b0, 1'b0, FWD_MEM, FWD_MEM);
        ins = enc_r(20, 0, 20, F_JALR);
        add_row(4, ins, 1'b0, 1'b1, FWD_RF, FWD_RF);
        add_row(4, ins, 1'b0, 1'b0, FWD_MEM, FWD_RF);   // bubble left in EX
        // 5: multiply/divide busy
        ins = enc_r(0, 0, 6, F_MFHI);
        add_row(5, ins, 1'b1, 1'b1, FWD_RF, FWD_RF);
        add_row(5, ins, 1'b1, 1'b1, FWD_RF, FWD_RF);
        add_row(5, ins, 1'b1, 1'b1, FWD_RF, FWD_RF);
        add_row(5, ins, 1'b0, 1'b0, FWD_RF, FWD_RF);
        add_row(5, enc_r(1, 2, 7, F_ADD), 1'b1, 1'b0, FWD_RF, FWD_RF);
        ins = enc_r(6, 2, 0, F_MULT);
        add_row(5, ins, 1'b1, 1'b1, FWD_MEM, FWD_RF);  // mfhi result in MEM
        add_row(5, ins, 1'b0, 1'b0, FWD_RF, FWD_RF);
    endtask

    initial begin
        row_t cur;
        clk          = 1'b0;
        rst_n        = 1'b0;
        mdu_busy     = 1'b0;
        row_errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        instr_id     = enc_r(8, 8, 8, F_ADD);  // would forward into row 0 if not flushed
        build_table();
        cycle_limit = table_q.size() + 10 + 20;

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < table_q.size(); i++) begin
            cur      = table_q[i];
            instr_id = cur.instr;
            mdu_busy = cur.busy;
            #28;    // outputs settled, well before the next edge
            check("stall_pc", 8'(stall_pc), 8'(cur.stall));
            check("stall_id", 8'(stall_id), 8'(cur.stall));
            check("clr_ex", 8'(clr_ex), 8'(cur.stall));
            check("fwd_rs", 8'(fwd_rs), 8'(cur.fwd_rs));
            check("fwd_rt", 8'(fwd_rt), 8'(cur.fwd_rt));
            if (i == table_q.size() - 1 || table_q[i + 1].test_id != cur.test_id) begin
                if (row_errors == 0) begin
                    tests_passed++;
                    $display("test %0d passed", cur.test_id);
                end else begin
                    tests_failed++;
                    $display("test %0d failed with %0d errors", cur.test_id, row_errors);
                end
                row_errors = 0;
            end
            @(posedge clk);
            #2;
        end

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/hazard_pkg.sv
rtl/instr_class.sv
rtl/instr_timing.sv
rtl/stage_reg.sv
rtl/hazard_unit.sv
rtl/forward_ctrl.sv
rtl/hazard_top.sv
test/hazard_assert.sv
test/hazard_tb.sv

// File: Makefile
TOP = hazard_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
